//--- src/iic_pkg.sv
//####################
// shared constants for the i2c master
// mode 3 falls back to standard rate
// the frame union is for the target model and testbench
//####################
package iic_pkg;

    // bus speed select, 2-bit mode input
    localparam logic [1:0] MODE_STD  = 2'd0;
    localparam logic [1:0] MODE_FAST = 2'd1;
    localparam logic [1:0] MODE_HS   = 2'd2;

    // bus rates in Hz
    localparam int unsigned STD_FREQ  = 32'd100_000;
    localparam int unsigned FAST_FREQ = 32'd400_000;
    localparam int unsigned HS_FREQ   = 32'd3_400_000;

    // bit operations from byte controller to bit controller
    localparam logic [1:0] BIT_START = 2'd0;
    localparam logic [1:0] BIT_STOP  = 2'd1;
    localparam logic [1:0] BIT_WRITE = 2'd2;
    localparam logic [1:0] BIT_READ  = 2'd3;

    // first byte after START, seen as raw data or as an address frame
    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic [6:0] dev_addr;
            logic       rw;
        } addr;
    } iic_frame_u;

endpackage

//--- src/iic_scl_gen.sv
//####################
// quarter-period tick for the bit controller
// divisor is CLK_FREQ / (4 * bus rate), floored, at least 1
// mode is used live, keep it steady during a command
//####################
`timescale 1ns/1ps

module iic_scl_gen #(
    parameter int unsigned CLK_FREQ = 50_000_000
) (
    input  logic       clk,
    input  logic       rst,
    input  logic [1:0] mode,
    input  logic       run,
    output logic       qtick
);

    // clocks per quarter bit period, never below one
    function automatic int unsigned quarter_div(input int unsigned rate);
        int unsigned q;
        q = CLK_FREQ / (4 * rate);
        if (q == 0) begin
            q = 1;
        end
        return q;
    endfunction

    localparam int unsigned Q_STD  = quarter_div(iic_pkg::STD_FREQ);
    localparam int unsigned Q_FAST = quarter_div(iic_pkg::FAST_FREQ);
    localparam int unsigned Q_HS   = quarter_div(iic_pkg::HS_FREQ);

    logic [31:0] reload;
    logic [31:0] cnt;

    // reload value, mode 3 runs at standard rate
    always_comb begin
        case (mode)
            iic_pkg::MODE_STD:  reload = Q_STD - 1;
            iic_pkg::MODE_FAST: reload = Q_FAST - 1;
            iic_pkg::MODE_HS:   reload = Q_HS - 1;
            default:            reload = Q_STD - 1;
        endcase
    end

    // held at reload while idle so the first quarter is full length
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= 32'd0;
        end else if (!run) begin
            cnt <= reload;
        end else if (cnt == 32'd0) begin
            cnt <= reload;
        end else begin
            cnt <= cnt - 32'd1;
        end
    end

    // one pulse every Q clocks while running
    assign qtick = run && (cnt == 32'd0);

endmodule

//--- src/iic_bit_ctrl.sv
//####################
// four-phase sequencer for one bus bit operation
// SCL is push-pull and never sampled, no clock stretching
// a new bit_go must wait for bit_done
//####################
`timescale 1ns/1ps

module iic_bit_ctrl (
    input  logic       clk,
    input  logic       rst,
    input  logic       qtick,
    input  logic       bit_go,
    input  logic [1:0] bit_cmd,
    input  logic       bit_txd,
    input  logic       sda_in,
    output logic       run,
    output logic       bit_done,
    output logic       bit_rxd,
    output logic       scl,
    output logic       sda_oe
);

    // phase of the current operation, 0 to 3
    logic [1:0] phase;
    logic [1:0] cmd_q;

    // levels change on the qtick that ends a phase, so each
    // phase holds its levels for one full quarter period
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            run      <= 1'b0;
            phase    <= 2'd0;
            cmd_q    <= iic_pkg::BIT_STOP;
            bit_done <= 1'b0;
            bit_rxd  <= 1'b1;
            scl      <= 1'b1;
            sda_oe   <= 1'b0;
        end else begin
            bit_done <= 1'b0;
            if (!run) begin
                if (bit_go) begin
                    run   <= 1'b1;
                    phase <= 2'd0;
                    cmd_q <= bit_cmd;
                    // phase 0 levels
                    case (bit_cmd)
                        iic_pkg::BIT_START: begin
                            // release sda, scl stays where it is
                            // so a start from idle has no glitch
                            sda_oe <= 1'b0;
                        end
                        iic_pkg::BIT_STOP: begin
                            // pull sda low while scl is still low
                            sda_oe <= 1'b1;
                        end
                        iic_pkg::BIT_WRITE: begin
                            scl    <= 1'b0;
                            sda_oe <= ~bit_txd;
                        end
                        default: begin
                            // read, let the target drive
                            scl    <= 1'b0;
                            sda_oe <= 1'b0;
                        end
                    endcase
                end
            end else if (qtick) begin
                phase <= phase + 2'd1;
                case (phase)
                    2'd0: begin
                        // every operation raises scl for phase 1
                        scl <= 1'b1;
                    end
                    2'd1: begin
                        if (cmd_q == iic_pkg::BIT_START) begin
                            // sda falls with scl high
                            sda_oe <= 1'b1;
                        end
                        if (cmd_q == iic_pkg::BIT_READ) begin
                            bit_rxd <= sda_in;
                        end
                    end
                    2'd2: begin
                        if (cmd_q == iic_pkg::BIT_STOP) begin
                            // sda rises with scl high, bus left idle
                            sda_oe <= 1'b0;
                        end else begin
                            scl <= 1'b0;
                        end
                    end
                    default: begin
                        // fourth qtick ends the operation
                        run      <= 1'b0;
                        bit_done <= 1'b1;
                    end
                endcase
            end
        end
    end

endmodule

//--- src/iic_byte_ctrl.sv
//####################
// byte command sequencer
// strobes are taken only while busy is low
// write and read run nine bit operations, the last is the ack
//####################
`timescale 1ns/1ps

module iic_byte_ctrl (
    input  logic       clk,
    input  logic       rst,
    input  logic       cmd_start,
    input  logic       cmd_stop,
    input  logic       cmd_write,
    input  logic       cmd_read,
    input  logic [7:0] data_in,
    input  logic       ack_in,
    input  logic       bit_done,
    input  logic       bit_rxd,
    output logic       busy,
    output logic       done,
    output logic [7:0] data_out,
    output logic       ack_out,
    output logic       bit_go,
    output logic [1:0] bit_cmd,
    output logic       bit_txd
);

    // command in progress, coded like the bit operations
    logic [1:0] op;
    logic [3:0] bit_cnt;
    logic [7:0] shreg;
    logic       ack_lat;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy     <= 1'b0;
            done     <= 1'b0;
            data_out <= 8'd0;
            ack_out  <= 1'b1;
            bit_go   <= 1'b0;
            bit_cmd  <= iic_pkg::BIT_STOP;
            bit_txd  <= 1'b1;
            op       <= iic_pkg::BIT_STOP;
            bit_cnt  <= 4'd0;
            shreg    <= 8'd0;
            ack_lat  <= 1'b1;
        end else begin
            done   <= 1'b0;
            bit_go <= 1'b0;
            if (!busy) begin
                // start wins over stop, stop over write, write over read
                if (cmd_start || cmd_stop || cmd_write || cmd_read) begin
                    busy    <= 1'b1;
                    bit_go  <= 1'b1;
                    bit_cnt <= 4'd0;
                    bit_txd <= 1'b1;
                    if (cmd_start) begin
                        op      <= iic_pkg::BIT_START;
                        bit_cmd <= iic_pkg::BIT_START;
                    end else if (cmd_stop) begin
                        op      <= iic_pkg::BIT_STOP;
                        bit_cmd <= iic_pkg::BIT_STOP;
                    end else if (cmd_write) begin
                        op      <= iic_pkg::BIT_WRITE;
                        bit_cmd <= iic_pkg::BIT_WRITE;
                        bit_txd <= data_in[7];
                        shreg   <= data_in;
                    end else begin
                        op      <= iic_pkg::BIT_READ;
                        bit_cmd <= iic_pkg::BIT_READ;
                        ack_lat <= ack_in;
                    end
                end
            end else if (bit_done) begin
                if (op == iic_pkg::BIT_START || op == iic_pkg::BIT_STOP) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end else if (bit_cnt == 4'd8) begin
                    // ack slot finished
                    if (op == iic_pkg::BIT_WRITE) begin
                        ack_out <= bit_rxd;
                    end else begin
                        data_out <= shreg;
                    end
                    busy <= 1'b0;
                    done <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                    bit_go  <= 1'b1;
                    if (op == iic_pkg::BIT_WRITE) begin
                        shreg <= {shreg[6:0], 1'b0};
                        if (bit_cnt == 4'd7) begin
                            // release sda for the target ack
                            bit_cmd <= iic_pkg::BIT_READ;
                            bit_txd <= 1'b1;
                        end else begin
                            bit_cmd <= iic_pkg::BIT_WRITE;
                            bit_txd <= shreg[6];
                        end
                    end else begin
                        shreg <= {shreg[6:0], bit_rxd};
                        if (bit_cnt == 4'd7) begin
                            // master answers ack or nack
                            bit_cmd <= iic_pkg::BIT_WRITE;
                            bit_txd <= ack_lat;
                        end else begin
                            bit_cmd <= iic_pkg::BIT_READ;
                        end
                    end
                end
            end
        end
    end

endmodule

//--- src/iic_master.sv
//####################
// i2c master top, push-pull SCL, open-drain SDA
// needs an external pull-up on sda
//####################
`timescale 1ns/1ps

module iic_master #(
    parameter int unsigned CLK_FREQ = 50_000_000
) (
    input  logic       clk,
    input  logic       rst,
    input  logic [1:0] mode,
    input  logic       cmd_start,
    input  logic       cmd_stop,
    input  logic       cmd_write,
    input  logic       cmd_read,
    input  logic [7:0] data_in,
    input  logic       ack_in,
    output logic       busy,
    output logic       done,
    output logic [7:0] data_out,
    output logic       ack_out,
    output logic       scl,
    inout  wire        sda
);

    logic       qtick;
    logic       run;
    logic       bit_go;
    logic [1:0] bit_cmd;
    logic       bit_txd;
    logic       bit_done;
    logic       bit_rxd;
    logic       sda_oe;

    // open drain, only ever pulls low
    assign sda = sda_oe ? 1'b0 : 1'bz;

    iic_scl_gen #(
        .CLK_FREQ(CLK_FREQ)
    ) u_scl_gen (
        .clk(clk), .rst(rst), .mode(mode), .run(run), .qtick(qtick)
    );

    iic_bit_ctrl u_bit_ctrl (
        .clk(clk), .rst(rst), .qtick(qtick), .bit_go(bit_go), .bit_cmd(bit_cmd),
        .bit_txd(bit_txd), .sda_in(sda), .run(run), .bit_done(bit_done),
        .bit_rxd(bit_rxd), .scl(scl), .sda_oe(sda_oe)
    );

    iic_byte_ctrl u_byte_ctrl (
        .clk(clk), .rst(rst), .cmd_start(cmd_start), .cmd_stop(cmd_stop),
        .cmd_write(cmd_write), .cmd_read(cmd_read), .data_in(data_in),
        .ack_in(ack_in), .bit_done(bit_done), .bit_rxd(bit_rxd), .busy(busy),
        .done(done), .data_out(data_out), .ack_out(ack_out), .bit_go(bit_go),
        .bit_cmd(bit_cmd), .bit_txd(bit_txd)
    );

endmodule

//--- dv/iic_target_model.sv
//####################
// behavioral i2c target, 16-byte memory
// first write byte sets the pointer, pointer wraps at 16
// no clock stretching, follows scl edges only
//####################
`timescale 1ns/1ps

module iic_target_model #(
    parameter logic [6:0] TARGET_ADDR = 7'h50
) (
    input  logic scl,
    inout  wire  sda
);

    logic [7:0] mem [0:15];
    logic [3:0] ptr;
    logic [7:0] shreg;
    int         bit_cnt;
    logic       active;
    logic       addr_phase;
    logic       ptr_phase;
    logic       reading;
    logic       tx_mode;
    logic       ack_next;
    logic       drive_low;
    iic_pkg::iic_frame_u frame;

    assign sda = drive_low ? 1'b0 : 1'bz;

    initial begin
        for (int i = 0; i < 16; i++) begin
            mem[i] = 8'(i * 37 + 5);
        end
        ptr       = 4'd0;
        shreg     = 8'd0;
        bit_cnt   = 0;
        active    = 1'b0;
        tx_mode   = 1'b0;
        reading   = 1'b0;
        ack_next  = 1'b0;
        drive_low = 1'b0;
    end

    // start or repeated start
    always @(negedge sda) begin
        if (scl === 1'b1) begin
            active     = 1'b1;
            addr_phase = 1'b1;
            ptr_phase  = 1'b0;
            reading    = 1'b0;
            tx_mode    = 1'b0;
            ack_next   = 1'b0;
            bit_cnt    = 0;
        end
    end

    // stop
    always @(posedge sda) begin
        if (scl === 1'b1) begin
            active  = 1'b0;
            tx_mode = 1'b0;
        end
    end

    task automatic take_byte();
        ack_next = 1'b1;
        if (addr_phase) begin
            frame.raw  = shreg;
            addr_phase = 1'b0;
            if (frame.addr.dev_addr != TARGET_ADDR) begin
                active   = 1'b0;
                ack_next = 1'b0;
            end else begin
                reading   = frame.addr.rw;
                ptr_phase = !frame.addr.rw;
            end
        end else if (ptr_phase) begin
            ptr       = shreg[3:0];
            ptr_phase = 1'b0;
        end else begin
            mem[ptr] = shreg;
            ptr      = ptr + 4'd1;
        end
    endtask

    always @(posedge scl) begin
        if (active) begin
            if (tx_mode) begin
                // nack from the master ends the read
                if (bit_cnt == 8 && sda !== 1'b0) begin
                    active  = 1'b0;
                    tx_mode = 1'b0;
                end
            end else if (bit_cnt < 8) begin
                shreg = {shreg[6:0], sda};
            end
            bit_cnt = bit_cnt + 1;
            if (bit_cnt == 8 && !tx_mode && active) begin
                take_byte();
            end
        end
    end

    always @(negedge scl) begin
        if (!active) begin
            drive_low = 1'b0;
        end else if (bit_cnt == 8) begin
            drive_low = tx_mode ? 1'b0 : ack_next;
        end else if (bit_cnt == 9) begin
            bit_cnt  = 0;
            ack_next = 1'b0;
            if (reading) begin
                tx_mode   = 1'b1;
                shreg     = mem[ptr];
                ptr       = ptr + 4'd1;
                drive_low = !shreg[7];
            end else begin
                drive_low = 1'b0;
            end
        end else if (tx_mode) begin
            drive_low = !shreg[7 - bit_cnt];
        end
    end

endmodule

//--- dv/iic_master_tb.sv
//####################
// directed tests for the i2c master with a target model
// stops at the first error, cycle limit guards hangs
//####################
`timescale 1ns/1ps

module iic_master_tb;

    localparam int unsigned CLK_FREQ = 125_000_000;
    localparam int unsigned Q_STD  = CLK_FREQ / (4 * iic_pkg::STD_FREQ);
    localparam int unsigned Q_FAST = CLK_FREQ / (4 * iic_pkg::FAST_FREQ);
    localparam int unsigned Q_HS   = CLK_FREQ / (4 * iic_pkg::HS_FREQ);
    // 50 byte commands in all tests, each under 40 Q at standard rate
    localparam int unsigned LIMIT  = 50 * 40 * Q_STD + 2000;

    logic       clk, rst, cmd_start, cmd_stop, cmd_write, cmd_read, ack_in;
    logic [1:0] mode;
    logic [7:0] data_in, data_out;
    logic       busy, done, ack_out, scl;
    wire        sda;
    logic [15:0] lfsr_state = 16'd7;
    logic [7:0] blk [0:3];
    logic [7:0] snap [0:15];
    int unsigned cycles = 0, done_cnt = 0, hi_cnt = 0, hi_checks = 0, q_exp = 0;
    logic       measure = 1'b0, measure_en = 1'b0;

    pullup (sda);

    iic_master #(.CLK_FREQ(CLK_FREQ)) UUT (
        .clk(clk), .rst(rst), .mode(mode), .cmd_start(cmd_start), .cmd_stop(cmd_stop),
        .cmd_write(cmd_write), .cmd_read(cmd_read), .data_in(data_in), .ack_in(ack_in),
        .busy(busy), .done(done), .data_out(data_out), .ack_out(ack_out), .scl(scl),
        .sda(sda)
    );

    iic_target_model #(.TARGET_ADDR(7'h50)) target (.scl(scl), .sda(sda));

    always #4 clk = ~clk;

    task automatic report_error(input string msg);
        $display("** Error at %0t ns: %s", $time, msg);
        $display("Some tests failed");
        $fatal(1, "stopped at first error");
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("timeout: no verdict after %0d clock cycles", LIMIT);
            $display("Some tests failed");
            $fatal(1, "stopped by cycle limit");
        end
    end

    // done pulses, counted mid-cycle
    always @(negedge clk) begin
        if (done) done_cnt++;
    end

    // scl high time, in clocks, during write commands
    always @(posedge clk) begin
        if (!measure) begin
            hi_cnt = 0;
        end else if (scl) begin
            hi_cnt++;
        end else if (hi_cnt != 0) begin
            assert (hi_cnt == 2 * q_exp)
            else report_error($sformatf("scl high %0d clocks, want %0d", hi_cnt, 2 * q_exp));
            hi_cnt = 0;
            hi_checks++;
        end
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic rand_byte(output logic [7:0] b);
        b = 8'd0;
        for (int i = 0; i < 8; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            b = {b[6:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [7:0] addr_frame(input logic [6:0] addr, input logic rw);
        iic_pkg::iic_frame_u f;
        f.addr.dev_addr = addr;
        f.addr.rw = rw;
        return f.raw;
    endfunction

    // one-clock strobe, 0 start, 1 stop, 2 write, 3 read
    task automatic issue_cmd(input int code, input logic [7:0] d, input logic a);
        @(posedge clk);
        case (code)
            0: cmd_start <= 1'b1;
            1: cmd_stop <= 1'b1;
            2: begin
                cmd_write <= 1'b1;
                data_in   <= d;
            end
            default: begin
                cmd_read <= 1'b1;
                ack_in   <= a;
            end
        endcase
        @(posedge clk);
        cmd_start <= 1'b0;
        cmd_stop  <= 1'b0;
        cmd_write <= 1'b0;
        cmd_read  <= 1'b0;
    endtask

    task automatic wait_done();
        do @(posedge clk); while (!done);
        assert (!busy) else report_error("busy still high with done");
    endtask

    task automatic send_start();
        issue_cmd(0, 8'd0, 1'b1);
        wait_done();
    endtask

    task automatic send_stop();
        issue_cmd(1, 8'd0, 1'b1);
        wait_done();
    endtask

    task automatic write_byte(input logic [7:0] d, input logic exp_ack);
        measure = measure_en;
        issue_cmd(2, d, 1'b1);
        wait_done();
        measure = 1'b0;
        assert (ack_out == exp_ack)
        else report_error($sformatf("ack_out %b after %h, want %b", ack_out, d, exp_ack));
    endtask

    task automatic read_byte(input logic a, input logic [7:0] exp);
        issue_cmd(3, 8'd0, a);
        wait_done();
        assert (data_out == exp)
        else report_error($sformatf("data_out %h, want %h", data_out, exp));
    endtask

    task automatic write_block(input logic [3:0] ptr, input int n);
        send_start();
        write_byte(addr_frame(7'h50, 1'b0), 1'b0);
        write_byte({4'd0, ptr}, 1'b0);
        for (int i = 0; i < n; i++) write_byte(blk[i], 1'b0);
        send_stop();
    endtask

    task automatic read_block(input logic [3:0] ptr, input int n);
        send_start();
        write_byte(addr_frame(7'h50, 1'b0), 1'b0);
        write_byte({4'd0, ptr}, 1'b0);
        send_start();
        write_byte(addr_frame(7'h50, 1'b1), 1'b0);
        for (int i = 0; i < n; i++) read_byte(i == n - 1, blk[i]);
        send_stop();
    endtask

    task automatic check_mem(input logic [3:0] ptr, input int n);
        for (int i = 0; i < n; i++) begin
            assert (target.mem[ptr + i] == blk[i])
            else report_error($sformatf("memory[%0d] %h, want %h", ptr + i,
                                        target.mem[ptr + i], blk[i]));
        end
    endtask

    task automatic test_reset();
        assert (scl && sda === 1'b1 && !busy && ack_out && data_out == 8'd0)
        else report_error("outputs wrong after reset");
    endtask

    task automatic test_write_std();
        mode <= iic_pkg::MODE_STD;
        for (int i = 0; i < 4; i++) rand_byte(blk[i]);
        write_block(4'd2, 4);
        check_mem(4'd2, 4);
    endtask

    task automatic test_read_fast();
        mode <= iic_pkg::MODE_FAST;
        read_block(4'd2, 4);
    endtask

    task automatic test_addr_nack();
        for (int i = 0; i < 16; i++) snap[i] = target.mem[i];
        send_start();
        write_byte(addr_frame(7'h51, 1'b0), 1'b1);
        write_byte(8'hA5, 1'b1);
        send_stop();
        for (int i = 0; i < 16; i++) begin
            assert (target.mem[i] == snap[i]) else report_error("memory changed by nack");
        end
    endtask

    task automatic test_speed();
        mode <= iic_pkg::MODE_HS;
        q_exp = Q_HS;
        hi_checks = 0;
        measure_en = 1'b1;
        for (int i = 0; i < 4; i++) rand_byte(blk[i]);
        write_block(4'd4, 4);
        read_block(4'd4, 4);
        // nine write commands, nine scl pulses each
        assert (hi_checks == 9 * 9) else report_error("missing scl intervals in hs mode");
        mode <= iic_pkg::MODE_FAST;
        q_exp = Q_FAST;
        hi_checks = 0;
        rand_byte(blk[0]);
        write_block(4'd12, 1);
        measure_en = 1'b0;
        assert (hi_checks == 27) else report_error("missing scl intervals in fast mode");
        check_mem(4'd12, 1);
    endtask

    task automatic test_busy_strobe();
        int unsigned d0;
        mode <= iic_pkg::MODE_HS;
        rand_byte(blk[0]);
        for (int i = 0; i < 16; i++) snap[i] = target.mem[i];
        send_start();
        write_byte(addr_frame(7'h50, 1'b0), 1'b0);
        write_byte(8'd8, 1'b0);
        d0 = done_cnt;
        issue_cmd(2, blk[0], 1'b1);
        repeat (10) @(posedge clk);
        // stray strobe in the middle of the byte
        issue_cmd(2, ~blk[0], 1'b1);
        wait_done();
        repeat (40) @(posedge clk);
        assert (done_cnt == d0 + 1) else report_error("strobe while busy gave extra done");
        send_stop();
        check_mem(4'd8, 1);
        assert (target.mem[9] == snap[9]) else report_error("stray byte stored at 9");
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        mode = iic_pkg::MODE_STD;
        cmd_start = 1'b0;
        cmd_stop = 1'b0;
        cmd_write = 1'b0;
        cmd_read = 1'b0;
        data_in = 8'd0;
        ack_in = 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        test_reset();
        test_write_std();
        test_read_fast();
        test_addr_nack();
        test_speed();
        test_busy_strobe();
        $display("All tests passed");
        $finish;
    end

endmodule

//--- build.f
src/iic_pkg.sv
src/iic_scl_gen.sv
src/iic_bit_ctrl.sv
src/iic_byte_ctrl.sv
src/iic_master.sv
dv/iic_target_model.sv
dv/iic_master_tb.sv

//--- Makefile
TOOL   = verilator
FLAGS  = --binary --timing --assert
LFLAGS = --lint-only --timing -Wall
TOP    = iic_master_tb
FLIST  = build.f
LOG    = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) -f $(FLIST) --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "All tests passed" $(LOG)

lint:
	$(TOOL) $(LFLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
